/* vlog.f */
source/video_link_pkg.sv
source/frame_start_sync.sv
source/line_buffer_afifo.sv
source/link_framer.sv
source/video_packet_send.sv
verification/tb_clock_gen.sv
verification/link_framer_checker.sv
verification/video_packet_send_tb.sv

/* Bender.yml */
package:
  name: video_packet_send

sources:
  - source/video_link_pkg.sv
  - source/frame_start_sync.sv
  - source/line_buffer_afifo.sv
  - source/link_framer.sv
  - source/video_packet_send.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/link_framer_checker.sv
      - verification/video_packet_send_tb.sv

/* verification/video_packet_send_tb.sv */
`timescale 1ns/10ps

module video_packet_send_tb
    import video_link_pkg::*;
();

    typedef struct packed {
        logic [3:0] mask;
        link_word_u word;
    } exp_word_t;

    typedef struct packed {
        logic [15:0] width;
        logic [15:0] lines;
        logic [15:0] gap; // idle pclk cycles after each line
    } frame_row_t;

    localparam int n_frames = 6;

    frame_row_t frame_table [n_frames] = '{
        '{16'd16, 16'd3, 16'd8},
        '{16'd64, 16'd2, 16'd30},
        '{16'd6,  16'd4, 16'd0}, // lines back to back
        '{16'd2,  16'd3, 16'd5},
        '{16'd8,  16'd0, 16'd4}, // sync only
        '{16'd40, 16'd2, 16'd12}
    };

    logic        tx_clk;
    logic        pclk;
    logic        rst;
    logic        vs;
    logic        de;
    logic [15:0] vin_data;
    logic [15:0] vin_width;
    link_word_u  gt_tx_data;
    logic [3:0]  gt_tx_ctrl;

    exp_word_t   expect_q [$];
    integer      seed;
    logic        first_seen = 1'b0;
    logic        in_line    = 1'b0;
    logic        prev_sync0 = 1'b0;
    int          first_wait = 0;
    int          idle_seen  = 0;

    tb_clock_gen tb_clock_gen_inst (
        .tx_clk (tx_clk),
        .pclk   (pclk),
        .rst    (rst)
    );

    video_packet_send #(
        .addr_w (11)
    ) video_packet_send_inst (
        .tx_clk     (tx_clk),
        .rst        (rst),
        .pclk       (pclk),
        .vs         (vs),
        .de         (de),
        .vin_data   (vin_data),
        .vin_width  (vin_width),
        .gt_tx_data (gt_tx_data),
        .gt_tx_ctrl (gt_tx_ctrl)
    );

    function automatic exp_word_t ctrl_expect(input logic [15:0] code);
        exp_word_t e;
        e.mask              = k_ctrl;
        e.word.ctrl.marker  = 8'hff;
        e.word.ctrl.code    = code;
        e.word.ctrl.comma   = 8'hbc;
        return e;
    endfunction

    function automatic exp_word_t pixel_expect(input logic [15:0] first,
                                               input logic [15:0] second);
        exp_word_t e;
        e.mask             = k_data;
        e.word.pix.pix_lo  = first;
        e.word.pix.pix_hi  = second;
        return e;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_on_error($sformatf("MISMATCH at %0t ns: %s", $time, msg));
    endtask

    task automatic check_control(input link_word_u got, input logic [3:0] mask);
        exp_word_t exp;
        if (expect_q.size() == 0)
            report_mismatch($sformatf("control word %h with nothing expected", got));
        else
        begin
            exp = expect_q.pop_front();
            if (exp.mask != k_ctrl)
                report_mismatch($sformatf("control word %h, expected pixels %h", got, exp.word));
            else if (mask != k_ctrl)
                report_mismatch($sformatf("mask %b on word %h, expected %b", mask, got, k_ctrl));
            else if (got !== exp.word)
                report_mismatch($sformatf("control word %h, expected %h", got, exp.word));
        end
    endtask

    task automatic check_pixels(input link_word_u got);
        exp_word_t exp;
        if (expect_q.size() == 0)
            report_mismatch($sformatf("pixel pair %h with nothing expected", got));
        else
        begin
            exp = expect_q.pop_front();
            if (exp.mask != k_data)
                report_mismatch($sformatf("pixel pair %h, expected control %h", got, exp.word));
            else if (got.pix.pix_lo !== exp.word.pix.pix_lo)
                report_mismatch($sformatf("first pixel %h, expected %h",
                                          got.pix.pix_lo, exp.word.pix.pix_lo));
            else if (got.pix.pix_hi !== exp.word.pix.pix_hi)
                report_mismatch($sformatf("second pixel %h, expected %h",
                                          got.pix.pix_hi, exp.word.pix.pix_hi));
        end
    endtask

    task automatic pclk_cycles(input int n);
        repeat (n) @(posedge pclk);
        #1;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expect_q.size() != 0 && cycles < 5000)
        begin
            @(posedge tx_clk);
            cycles++;
        end
        if (expect_q.size() != 0)
            stop_on_error($sformatf("timeout: %0d expected words never arrived",
                                    expect_q.size()));
    endtask

    task automatic send_frame(input frame_row_t row);
        logic [15:0] first_pix;
        logic [15:0] pix;
        pclk_cycles(25); // quiet before the vs edge
        vs = 1'b1;
        expect_q.push_back(ctrl_expect(16'h0000));
        expect_q.push_back(ctrl_expect(16'h0001));
        pclk_cycles(25);
        vs        = 1'b0;
        vin_width = row.width; // old frame already flushed
        pclk_cycles(25);
        for (int l = 0; l < row.lines; l++)
        begin
            expect_q.push_back(ctrl_expect(16'h0002));
            for (int p = 0; p < row.width; p++)
            begin
                pix      = 16'($random(seed));
                de       = 1'b1;
                vin_data = pix;
                if (p % 2 == 0)
                    first_pix = pix;
                else
                    expect_q.push_back(pixel_expect(first_pix, pix));
                pclk_cycles(1);
            end
            expect_q.push_back(ctrl_expect(16'h0003));
            de       = 1'b0;
            vin_data = 16'd0;
            pclk_cycles(row.gap);
        end
        for (int p = 0; p < row.width / 2; p++) // half line, never sent
        begin
            de       = 1'b1;
            vin_data = 16'($random(seed));
            pclk_cycles(1);
        end
        de       = 1'b0;
        vin_data = 16'd0;
        wait_drain();
    endtask

    // link side monitor, outputs settle well before the falling edge
    always @(negedge tx_clk)
    begin
        if (rst)
        begin
            if (gt_tx_ctrl !== 4'd0 || gt_tx_data !== 32'd0)
                report_mismatch("outputs not zero during reset");
        end
        else if (!first_seen)
        begin
            if (gt_tx_ctrl === 4'd0 && gt_tx_data === 32'd0)
            begin
                first_wait++;
                if (first_wait > 4)
                    stop_on_error("no link word arrived after reset release");
            end
            else if (gt_tx_ctrl !== k_ctrl || gt_tx_data.ctrl.code !== 16'h5555)
                report_mismatch($sformatf("first word %h is not idle A", gt_tx_data));
            else
                first_seen = 1'b1;
        end
        else if (gt_tx_ctrl == k_ctrl && (gt_tx_data.ctrl.code == 16'h5555 ||
                                          gt_tx_data.ctrl.code == 16'haaaa))
        begin
            idle_seen++;
            if (in_line)
                report_mismatch("idle word inside a line");
        end
        else if (gt_tx_ctrl == k_ctrl && gt_tx_data.ctrl.code == 16'h0001 && !prev_sync0)
            report_mismatch("frame sync 1 not directly after frame sync 0");
        else if (gt_tx_ctrl == k_data)
            check_pixels(gt_tx_data);
        else
        begin
            check_control(gt_tx_data, gt_tx_ctrl);
            in_line = (gt_tx_data.ctrl.code == 16'h0002);
        end
        prev_sync0 = !rst && gt_tx_ctrl == k_ctrl && gt_tx_data.ctrl.code == 16'h0000;
    end

    initial
    begin
        int cycles;
        int idle_before;
        vs        = 1'b0;
        de        = 1'b0;
        vin_data  = 16'd0;
        vin_width = frame_table[0].width;
        seed      = 32'h0b5d94d7;
        cycles    = 0;
        while (rst !== 1'b0 && cycles < 100)
        begin
            @(posedge tx_clk);
            cycles++;
        end
        if (rst !== 1'b0)
            stop_on_error("timeout waiting for reset release");
        for (int f = 0; f < n_frames; f++)
            send_frame(frame_table[f]);
        idle_before = idle_seen;
        pclk_cycles(100); // less than a line buffered, filler only
        if (idle_seen - idle_before < 50)
            stop_on_error("link did not settle into idle filler at the end");
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* verification/link_framer_checker.sv */
`timescale 1ns/10ps

module link_framer_checker
    import video_link_pkg::*;
(
    input logic       tx_clk,
    input logic       rst,
    input link_word_u gt_tx_data,
    input logic [3:0] gt_tx_ctrl
);

    logic is_ctrl;
    logic is_idle_a;
    logic is_idle_b;
    logic is_sync0;

    assign is_ctrl   = (gt_tx_ctrl == k_ctrl);
    assign is_idle_a = is_ctrl && (gt_tx_data.ctrl.code == code_idle_a);
    assign is_idle_b = is_ctrl && (gt_tx_data.ctrl.code == code_idle_b);
    assign is_sync0  = is_ctrl && (gt_tx_data.ctrl.code == code_frame_sync0);

    mask_legal: assert property (@(posedge tx_clk) disable iff (rst)
        (gt_tx_ctrl == k_ctrl) || (gt_tx_ctrl == k_data))
        else $error("illegal control mask %b", gt_tx_ctrl);

    ctrl_framing: assert property (@(posedge tx_clk) disable iff (rst)
        is_ctrl |-> (gt_tx_data.ctrl.comma == comma_byte) &&
                    (gt_tx_data.ctrl.marker == marker_byte))
        else $error("control word %h without comma or marker byte", gt_tx_data);

    // a frame sync may cut into the idle pair
    idle_pair: assert property (@(posedge tx_clk) disable iff (rst)
        is_idle_a |=> (is_idle_b || is_sync0))
        else $error("idle A not followed by idle B");

endmodule

bind link_framer link_framer_checker link_framer_checker_inst (
    .tx_clk     (tx_clk),
    .rst        (rst),
    .gt_tx_data (gt_tx_data),
    .gt_tx_ctrl (gt_tx_ctrl)
);

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen
(
    output logic tx_clk,
    output logic pclk,
    output logic rst
);

    initial
    begin
        tx_clk = 1'b0;
        pclk   = 1'b0;
        rst    = 1'b1;
        repeat (5) @(posedge tx_clk);
        #1 rst = 1'b0; // released just after the fifth edge
    end

    always #5 tx_clk = ~tx_clk;
    always #6.5 pclk = ~pclk; // 13 ns camera clock

endmodule

/* source/video_packet_send.sv */
`timescale 1ns/10ps

module video_packet_send
    import video_link_pkg::*;
#(
    parameter int addr_w = 11 // 2048 words, 4096 pixels
)
(
    input  logic        tx_clk,
    input  logic        rst,
    input  logic        pclk,
    input  logic        vs,
    input  logic        de,
    input  logic [15:0] vin_data,
    input  logic [15:0] vin_width,
    output link_word_u  gt_tx_data,
    output logic [3:0]  gt_tx_ctrl
);

    pixel_in_t   pix_in;
    logic        wr_flush;
    logic        frame_start;
    logic [15:0] level_pix;
    logic        rd_en;
    link_word_u  rd_data;

    assign pix_in = '{de: de, data: vin_data};

    frame_start_sync frame_start_sync_inst (
        .tx_clk      (tx_clk),
        .pclk        (pclk),
        .rst         (rst),
        .vs          (vs),
        .frame_start (frame_start),
        .wr_flush    (wr_flush)
    );

    line_buffer_afifo #(
        .addr_w (addr_w)
    ) line_buffer_afifo_inst (
        .pclk        (pclk),
        .tx_clk      (tx_clk),
        .rst         (rst),
        .wr_flush    (wr_flush),
        .frame_start (frame_start),
        .rd_en       (rd_en),
        .pix_in      (pix_in),
        .rd_data     (rd_data),
        .level_pix   (level_pix)
    );

    link_framer link_framer_inst (
        .tx_clk      (tx_clk),
        .rst         (rst),
        .frame_start (frame_start),
        .vin_width   (vin_width),
        .level_pix   (level_pix),
        .rd_data     (rd_data),
        .rd_en       (rd_en),
        .gt_tx_data  (gt_tx_data),
        .gt_tx_ctrl  (gt_tx_ctrl)
    );

endmodule

/* source/link_framer.sv */
`timescale 1ns/10ps

module link_framer
    import video_link_pkg::*;
(
    input  logic        tx_clk,
    input  logic        rst,
    input  logic        frame_start,
    input  logic [15:0] vin_width,
    input  logic [15:0] level_pix,
    input  link_word_u  rd_data,
    output logic        rd_en,
    output link_word_u  gt_tx_data,
    output logic [3:0]  gt_tx_ctrl
);

    // state names the word sent at the next edge
    localparam logic [2:0] st_frame_sync1 = 3'd1;
    localparam logic [2:0] st_line_start  = 3'd2;
    localparam logic [2:0] st_line_data   = 3'd3;
    localparam logic [2:0] st_line_end    = 3'd4;
    localparam logic [2:0] st_idle_a      = 3'd5;
    localparam logic [2:0] st_idle_b      = 3'd6;

    logic [2:0]  state;
    logic [15:0] beat;       // reads issued in this line
    logic [15:0] beat_nxt;
    logic [15:0] line_words; // pixel pairs per line
    logic        line_ready;

    assign line_words = {1'b0, vin_width[15:1]};
    assign beat_nxt   = beat + 16'd1;
    assign line_ready = (level_pix >= vin_width) && (line_words != 16'd0);

    function automatic link_word_u ctrl_word(input logic [15:0] code);
        link_word_u w;
        w.ctrl.marker = marker_byte;
        w.ctrl.code   = code;
        w.ctrl.comma  = comma_byte;
        return w;
    endfunction

    always_ff @(posedge tx_clk or posedge rst)
    begin
        if (rst)
        begin
            state      <= st_idle_a;
            beat       <= 16'd0;
            rd_en      <= 1'b0;
            gt_tx_data <= '0;
            gt_tx_ctrl <= 4'd0;
        end
        else if (frame_start)
        begin
            // abandon any line in progress
            state      <= st_frame_sync1;
            rd_en      <= 1'b0;
            gt_tx_data <= ctrl_word(code_frame_sync0);
            gt_tx_ctrl <= k_ctrl;
        end
        else
        begin
            case (state)
                st_frame_sync1:
                begin
                    state      <= st_idle_a;
                    gt_tx_data <= ctrl_word(code_frame_sync1);
                    gt_tx_ctrl <= k_ctrl;
                end
                st_idle_a:
                begin
                    state      <= st_idle_b;
                    gt_tx_data <= ctrl_word(code_idle_a);
                    gt_tx_ctrl <= k_ctrl;
                end
                st_idle_b:
                begin
                    if (line_ready)
                    begin
                        state <= st_line_start;
                        rd_en <= 1'b1; // first read overlaps line start
                        beat  <= 16'd0;
                    end
                    else
                        state <= st_idle_a;
                    gt_tx_data <= ctrl_word(code_idle_b);
                    gt_tx_ctrl <= k_ctrl;
                end
                st_line_start:
                begin
                    state      <= st_line_data;
                    beat       <= beat_nxt;
                    rd_en      <= (beat_nxt < line_words);
                    gt_tx_data <= ctrl_word(code_line_start);
                    gt_tx_ctrl <= k_ctrl;
                end
                st_line_data:
                begin
                    if (rd_en)
                    begin
                        beat  <= beat_nxt;
                        rd_en <= (beat_nxt < line_words);
                    end
                    else
                        state <= st_line_end; // last pair goes out now
                    gt_tx_data <= rd_data;
                    gt_tx_ctrl <= k_data;
                end
                st_line_end:
                begin
                    state      <= st_idle_a;
                    gt_tx_data <= ctrl_word(code_line_end);
                    gt_tx_ctrl <= k_ctrl;
                end
                default:
                begin
                    state <= st_idle_a;
                    rd_en <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* source/line_buffer_afifo.sv */
`timescale 1ns/10ps

module line_buffer_afifo
    import video_link_pkg::*;
#(
    parameter int addr_w = 11
)
(
    input  logic        pclk,
    input  logic        tx_clk,
    input  logic        rst,
    input  logic        wr_flush,
    input  logic        frame_start,
    input  logic        rd_en,
    input  pixel_in_t   pix_in,
    output link_word_u  rd_data,
    output logic [15:0] level_pix
);

    link_word_u mem [2**addr_w];

    logic [15:0]     pix_lo; // first pixel of the pair
    logic            half;   // low half holds a pixel
    link_word_u      wr_word;
    logic            wr_commit;
    logic            full;
    logic [addr_w:0] wr_bin;
    logic [addr_w:0] wr_gray;
    logic [addr_w:0] wr_used;
    logic [addr_w:0] rd_gray_s1;
    logic [addr_w:0] rd_gray_s2;

    logic [addr_w:0] rd_bin;
    logic [addr_w:0] rd_gray;
    logic [addr_w:0] wr_gray_s1;
    logic [addr_w:0] wr_gray_s2;
    logic [addr_w:0] rd_words;
    logic            empty;
    logic            flushing; // write side may still hold the old frame
    logic [31:0]     pix_cnt;

    function automatic logic [addr_w:0] bin2gray(input logic [addr_w:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [addr_w:0] gray2bin(input logic [addr_w:0] g);
        logic [addr_w:0] b;
        b[addr_w] = g[addr_w];
        for (int i = addr_w - 1; i >= 0; i--)
        begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    always_comb
    begin
        wr_word.pix.pix_hi = pix_in.data;
        wr_word.pix.pix_lo = pix_lo;
    end

    assign wr_used   = wr_bin - gray2bin(rd_gray_s2);
    assign full      = wr_used[addr_w];
    assign wr_commit = pix_in.de & half & ~full & ~wr_flush; // full drops the pair

    always_ff @(posedge pclk)
    begin
        if (pix_in.de && !half)
            pix_lo <= pix_in.data;
        if (wr_commit)
            mem[wr_bin[addr_w-1:0]] <= wr_word;
    end

    always_ff @(posedge pclk or posedge rst)
    begin
        if (rst)
        begin
            half       <= 1'b0;
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end
        else
        begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (wr_flush)
            begin
                half    <= 1'b0;
                wr_bin  <= '0;
                wr_gray <= '0;
            end
            else if (pix_in.de)
            begin
                half <= ~half;
                if (wr_commit)
                begin
                    wr_bin  <= wr_bin + 1'b1;
                    wr_gray <= bin2gray(wr_bin + 1'b1);
                end
            end
        end
    end

    assign rd_words = gray2bin(wr_gray_s2) - rd_bin;
    assign empty    = (rd_words == '0);

    always_ff @(posedge tx_clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_bin[addr_w-1:0]];
    end

    always_ff @(posedge tx_clk or posedge rst)
    begin
        if (rst)
        begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            flushing   <= 1'b0;
        end
        else
        begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (frame_start)
            begin
                rd_bin   <= '0;
                rd_gray  <= '0;
                flushing <= 1'b1;
            end
            else
            begin
                if (wr_gray_s2 == '0)
                    flushing <= 1'b0; // write side cleared too
                if (rd_en && !empty)
                begin
                    rd_bin  <= rd_bin + 1'b1;
                    rd_gray <= bin2gray(rd_bin + 1'b1);
                end
            end
        end
    end

    // two pixels per word, clipped to the port width
    assign pix_cnt   = 32'(rd_words) << 1;
    assign level_pix = flushing ? 16'd0 :
                       (pix_cnt > 32'h0000_ffff) ? 16'hffff : pix_cnt[15:0];

endmodule

/* source/frame_start_sync.sv */
`timescale 1ns/10ps

module frame_start_sync
(
    input  logic tx_clk,
    input  logic pclk,
    input  logic rst,
    input  logic vs,
    output logic frame_start,
    output logic wr_flush
);

    logic vs_tx_d0;
    logic vs_tx_d1;
    logic vs_tx_d2;

    logic vs_pclk_d0;
    logic vs_pclk_d1;
    logic vs_pclk_d2;

    always_ff @(posedge tx_clk or posedge rst)
    begin
        if (rst)
        begin
            vs_tx_d0    <= 1'b0;
            vs_tx_d1    <= 1'b0;
            vs_tx_d2    <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            vs_tx_d0    <= vs; // async input
            vs_tx_d1    <= vs_tx_d0;
            vs_tx_d2    <= vs_tx_d1;
            frame_start <= vs_tx_d1 & ~vs_tx_d2; // rising edge
        end
    end

    // same edge detect on the camera side for the write pointer flush
    always_ff @(posedge pclk or posedge rst)
    begin
        if (rst)
        begin
            vs_pclk_d0 <= 1'b0;
            vs_pclk_d1 <= 1'b0;
            vs_pclk_d2 <= 1'b0;
            wr_flush   <= 1'b0;
        end
        else
        begin
            vs_pclk_d0 <= vs;
            vs_pclk_d1 <= vs_pclk_d0;
            vs_pclk_d2 <= vs_pclk_d1;
            wr_flush   <= vs_pclk_d1 & ~vs_pclk_d2;
        end
    end

endmodule

/* source/video_link_pkg.sv */
package video_link_pkg;

    // control view of a link word, comma byte goes out first
    typedef struct packed {
        logic [7:0]  marker;
        logic [15:0] code;
        logic [7:0]  comma;
    } ctrl_word_t;

    // pixel view, first pixel of the pair in the low half
    typedef struct packed {
        logic [15:0] pix_hi;
        logic [15:0] pix_lo;
    } pix_word_t;

    typedef union packed {
        ctrl_word_t ctrl;
        pix_word_t  pix;
    } link_word_u;

    // camera side input, one pixel per pclk when de is high
    typedef struct packed {
        logic        de;
        logic [15:0] data;
    } pixel_in_t;

    localparam logic [15:0] code_frame_sync0 = 16'h0000;
    localparam logic [15:0] code_frame_sync1 = 16'h0001;
    localparam logic [15:0] code_line_start  = 16'h0002;
    localparam logic [15:0] code_line_end    = 16'h0003;
    localparam logic [15:0] code_idle_a      = 16'h5555; // filler, always paired
    localparam logic [15:0] code_idle_b      = 16'haaaa;

    localparam logic [7:0]  comma_byte  = 8'hbc; // k28.5 on the lane
    localparam logic [7:0]  marker_byte = 8'hff;

    localparam logic [3:0]  k_ctrl = 4'b0001; // byte 0 is a k character
    localparam logic [3:0]  k_data = 4'b0000;

endpackage
